// File: common/mem_params_pkg.sv
package mem_params_pkg;

  // Memory array size in bytes
  localparam int MEM_SIZE = 1024;

  // Byte address width, enough to cover MEM_SIZE
  localparam int ADDR_WIDTH = 10;

  // Data path width, fixed by the byte and word access rules
  localparam int DATA_WIDTH = 32;

  // Pipeline depth from accepted request to read response
  localparam int MEM_LATENCY = 10;

endpackage

// File: common/mem_types_pkg.sv
package mem_types_pkg;

  typedef enum logic {
    BYTE = 1'b0,  // Single byte, zero-extended on load
    WORD = 1'b1   // Four bytes, little-endian, 4-byte aligned
  } access_size_t;

  // Owner of a request and of its response
  typedef enum logic {
    SRC_INSTR = 1'b0,
    SRC_DATA  = 1'b1
  } req_src_t;

  // Round-robin preference of the arbiter
  typedef enum logic {
    PREFER_INSTR = 1'b0,
    PREFER_DATA  = 1'b1
  } arb_state_t;

  typedef struct packed {
    logic                                  valid;
    logic                                  is_wr;  // Store when high, load otherwise
    req_src_t                              src;
    access_size_t                          size;
    logic [mem_params_pkg::ADDR_WIDTH-1:0] addr;
    logic [mem_params_pkg::DATA_WIDTH-1:0] wdata;
  } mem_req_t;

  typedef struct packed {
    logic                                  valid;
    req_src_t                              src;
    logic [mem_params_pkg::DATA_WIDTH-1:0] rdata;
  } mem_rsp_t;

endpackage

// File: memory/main_mem.sv
module main_mem #(
  parameter int MEM_SIZE   = mem_params_pkg::MEM_SIZE,
  parameter int ADDR_WIDTH = mem_params_pkg::ADDR_WIDTH
) (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  mem_types_pkg::mem_req_t req_i,
  output mem_types_pkg::mem_rsp_t rsp_o
);
  import mem_params_pkg::*;
  import mem_types_pkg::*;

  // Request half ends at the array access, response half carries read data
  localparam int REQ_STAGES = MEM_LATENCY / 2;
  localparam int RSP_STAGES = MEM_LATENCY - REQ_STAGES;

  logic [7:0] mem [MEM_SIZE] = '{default: 8'h00};

  mem_req_t req_q [REQ_STAGES];
  mem_rsp_t rsp_q [RSP_STAGES];

  mem_req_t              acc;        // Request at the access stage
  logic [ADDR_WIDTH-1:0] acc_addr;
  logic [ADDR_WIDTH-3:0] word_base;  // Word index of the access
  mem_rsp_t              rd_rsp;

  assign acc       = req_q[REQ_STAGES-1];
  assign acc_addr  = acc.addr;
  assign word_base = acc_addr[ADDR_WIDTH-1:2];

  // Array read at the access stage, sees writes committed on earlier edges
  always_comb begin
    rd_rsp       = '0;
    rd_rsp.valid = acc.valid && !acc.is_wr;  // Stores return nothing
    rd_rsp.src   = acc.src;
    if (acc.size == WORD) begin
      rd_rsp.rdata = {
        mem[{word_base, 2'd3}],
        mem[{word_base, 2'd2}],
        mem[{word_base, 2'd1}],
        mem[{word_base, 2'd0}]
      };
    end else begin
      rd_rsp.rdata = DATA_WIDTH'(mem[acc_addr]);  // Zero-extend
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < REQ_STAGES; i++) begin
        req_q[i].valid <= 1'b0;
      end
      for (int i = 0; i < RSP_STAGES; i++) begin
        rsp_q[i].valid <= 1'b0;
      end
    end else begin
      req_q[0] <= req_i;
      for (int i = 1; i < REQ_STAGES; i++) begin
        req_q[i] <= req_q[i-1];
      end
      rsp_q[0] <= rd_rsp;
      for (int i = 1; i < RSP_STAGES; i++) begin
        rsp_q[i] <= rsp_q[i-1];
      end
    end
  end

  // Store commit, low byte first
  always_ff @(posedge clk_i) begin
    if (acc.valid && acc.is_wr) begin
      if (acc.size == WORD) begin
        mem[{word_base, 2'd0}] <= acc.wdata[7:0];
        mem[{word_base, 2'd1}] <= acc.wdata[15:8];
        mem[{word_base, 2'd2}] <= acc.wdata[23:16];
        mem[{word_base, 2'd3}] <= acc.wdata[31:24];
      end else begin
        mem[acc_addr] <= acc.wdata[7:0];
      end
    end
  end

  assign rsp_o = rsp_q[RSP_STAGES-1];

  // Struct address field is sized by the package, so the widths must agree
  initial begin
    a_addr_width: assert (ADDR_WIDTH == mem_params_pkg::ADDR_WIDTH)
      else $error("main_mem ADDR_WIDTH differs from the request address field");
  end

  a_word_aligned: assert property (
    @(posedge clk_i) disable iff (!rst_i)
    req_i.valid && req_i.size == WORD |-> req_i.addr[1:0] == 2'b00
  ) else $error("Unaligned word access");

  a_addr_range: assert property (
    @(posedge clk_i) disable iff (!rst_i)
    req_i.valid |-> req_i.addr < MEM_SIZE
  ) else $error("Access beyond the memory array");

endmodule

// File: memory/mem_arbiter.sv
module mem_arbiter (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  mem_types_pkg::mem_req_t instr_req_i,
  input  mem_types_pkg::mem_req_t data_req_i,
  output logic                    instr_gnt_o,
  output logic                    data_gnt_o,
  output mem_types_pkg::mem_req_t mem_req_o,
  input  mem_types_pkg::mem_rsp_t mem_rsp_i,
  output mem_types_pkg::mem_rsp_t instr_rsp_o,
  output mem_types_pkg::mem_rsp_t data_rsp_o
);
  import mem_types_pkg::*;

  arb_state_t pref_q;
  logic       contest;  // Both sides want the memory

  assign contest = instr_req_i.valid && data_req_i.valid;

  // A lone requester always wins and a contest goes to the preferred side
  always_comb begin
    instr_gnt_o = instr_req_i.valid && (!data_req_i.valid || pref_q == PREFER_INSTR);
    data_gnt_o  = data_req_i.valid && (!instr_req_i.valid || pref_q == PREFER_DATA);
  end

  always_comb begin
    mem_req_o = '0;
    if (instr_gnt_o) begin
      mem_req_o = instr_req_i;
    end else if (data_gnt_o) begin
      mem_req_o = data_req_i;
    end
  end

  // Loser of a contest is preferred next time
  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      pref_q <= PREFER_DATA;
    end else if (contest) begin
      pref_q <= (pref_q == PREFER_DATA) ? PREFER_INSTR : PREFER_DATA;
    end
  end

  // Responses return in order and the tag alone picks the destination
  always_comb begin
    instr_rsp_o       = mem_rsp_i;
    data_rsp_o        = mem_rsp_i;
    instr_rsp_o.valid = mem_rsp_i.valid && (mem_rsp_i.src == SRC_INSTR);
    data_rsp_o.valid  = mem_rsp_i.valid && (mem_rsp_i.src == SRC_DATA);
  end

  // Back-to-back contests alternate between the two sides
  a_round_robin: assert property (
    @(posedge clk_i) disable iff (!rst_i)
    contest |=> !contest || (instr_gnt_o != $past(instr_gnt_o))
  ) else $error("Contest granted to the same side twice in a row");

endmodule

// File: rtl/fetch_port.sv
module fetch_port (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  fetch_i,
  input  logic [mem_params_pkg::ADDR_WIDTH-1:0] fetch_addr_i,
  output logic                                  busy_o,
  output mem_types_pkg::mem_req_t               req_o,
  input  logic                                  gnt_i,
  input  mem_types_pkg::mem_rsp_t               rsp_i,
  output logic                                  instr_valid_o,
  output logic [mem_params_pkg::DATA_WIDTH-1:0] instr_o
);
  import mem_types_pkg::*;

  mem_req_t new_req;
  mem_req_t hold_q;       // Request that lost arbitration
  logic     hold_full_q;

  // Fetches are always word reads
  always_comb begin
    new_req       = '0;
    new_req.valid = fetch_i;
    new_req.is_wr = 1'b0;
    new_req.src   = SRC_INSTR;
    new_req.size  = WORD;
    new_req.addr  = fetch_addr_i;
  end

  assign req_o  = hold_full_q ? hold_q : new_req;
  assign busy_o = hold_full_q;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      hold_full_q <= 1'b0;
    end else if (req_o.valid) begin
      hold_full_q <= !gnt_i;  // Cleared once the held request is granted
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_o.valid && !gnt_i) begin
      hold_q <= req_o;
    end
  end

  assign instr_valid_o = rsp_i.valid;
  assign instr_o       = rsp_i.rdata;

  a_no_fetch_busy: assert property (
    @(posedge clk_i) disable iff (!rst_i)
    busy_o |-> !fetch_i
  ) else $error("Fetch strobe while fetch port is busy");

endmodule

// File: rtl/load_store_port.sv
module load_store_port (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  input  logic                                  rd_i,
  input  logic                                  wr_i,
  input  logic [mem_params_pkg::ADDR_WIDTH-1:0] addr_i,
  input  logic [mem_params_pkg::DATA_WIDTH-1:0] wdata_i,
  input  mem_types_pkg::access_size_t           size_i,
  output logic                                  busy_o,
  output mem_types_pkg::mem_req_t               req_o,
  input  logic                                  gnt_i,
  input  mem_types_pkg::mem_rsp_t               rsp_i,
  output logic                                  ld_valid_o,
  output logic [mem_params_pkg::DATA_WIDTH-1:0] ld_data_o
);
  import mem_types_pkg::*;

  mem_req_t new_req;
  mem_req_t hold_q;       // Load or store waiting for a grant
  logic     hold_full_q;

  always_comb begin
    new_req       = '0;
    new_req.valid = rd_i || wr_i;
    new_req.is_wr = wr_i;
    new_req.src   = SRC_DATA;
    new_req.size  = size_i;
    new_req.addr  = addr_i;
    new_req.wdata = wdata_i;  // Ignored by the memory on loads
  end

  assign req_o  = hold_full_q ? hold_q : new_req;
  assign busy_o = hold_full_q;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      hold_full_q <= 1'b0;
    end else if (req_o.valid) begin
      hold_full_q <= !gnt_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_o.valid && !gnt_i) begin
      hold_q <= req_o;
    end
  end

  // Only loads come back, stores are silent
  assign ld_valid_o = rsp_i.valid;
  assign ld_data_o  = rsp_i.rdata;

  a_rd_wr_excl: assert property (
    @(posedge clk_i) disable iff (!rst_i)
    !(rd_i && wr_i)
  ) else $error("Load and store strobed together");

  a_no_strobe_busy: assert property (
    @(posedge clk_i) disable iff (!rst_i)
    busy_o |-> !(rd_i || wr_i)
  ) else $error("Load/store strobe while port is busy");

endmodule

// File: rtl/mem_subsystem.sv
module mem_subsystem #(
  parameter int MEM_SIZE   = mem_params_pkg::MEM_SIZE,
  parameter int ADDR_WIDTH = mem_params_pkg::ADDR_WIDTH
) (
  input  logic                                  clk_i,
  input  logic                                  rst_i,
  // Instruction side
  input  logic                                  fetch_i,
  input  logic [ADDR_WIDTH-1:0]                 fetch_addr_i,
  output logic                                  fetch_busy_o,
  output logic                                  instr_valid_o,
  output logic [mem_params_pkg::DATA_WIDTH-1:0] instr_o,
  // Data side
  input  logic                                  rd_i,
  input  logic                                  wr_i,
  input  logic [ADDR_WIDTH-1:0]                 addr_i,
  input  logic [mem_params_pkg::DATA_WIDTH-1:0] wdata_i,
  input  mem_types_pkg::access_size_t           size_i,
  output logic                                  ls_busy_o,
  output logic                                  ld_valid_o,
  output logic [mem_params_pkg::DATA_WIDTH-1:0] ld_data_o
);
  import mem_types_pkg::*;

  mem_req_t instr_req;
  mem_req_t data_req;
  mem_req_t mem_req;
  logic     instr_gnt;
  logic     data_gnt;
  mem_rsp_t mem_rsp;
  mem_rsp_t instr_rsp;
  mem_rsp_t data_rsp;

  fetch_port fetch_port_i (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .fetch_i       (fetch_i),
    .fetch_addr_i  (fetch_addr_i),
    .busy_o        (fetch_busy_o),
    .req_o         (instr_req),
    .gnt_i         (instr_gnt),
    .rsp_i         (instr_rsp),
    .instr_valid_o (instr_valid_o),
    .instr_o       (instr_o)
  );

  load_store_port load_store_port_i (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .rd_i       (rd_i),
    .wr_i       (wr_i),
    .addr_i     (addr_i),
    .wdata_i    (wdata_i),
    .size_i     (size_i),
    .busy_o     (ls_busy_o),
    .req_o      (data_req),
    .gnt_i      (data_gnt),
    .rsp_i      (data_rsp),
    .ld_valid_o (ld_valid_o),
    .ld_data_o  (ld_data_o)
  );

  mem_arbiter mem_arbiter_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .instr_req_i (instr_req),
    .data_req_i  (data_req),
    .instr_gnt_o (instr_gnt),
    .data_gnt_o  (data_gnt),
    .mem_req_o   (mem_req),
    .mem_rsp_i   (mem_rsp),
    .instr_rsp_o (instr_rsp),
    .data_rsp_o  (data_rsp)
  );

  main_mem #(
    .MEM_SIZE   (MEM_SIZE),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) main_mem_i (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .req_i (mem_req),
    .rsp_o (mem_rsp)
  );

endmodule

// File: test/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

localparam int WAIT_LIMIT = 40;  // Cycles before a wait gives up

task automatic fail_and_stop();
  $display("Simulation failed");
  $fatal(1);
endtask

task automatic check_value(input string test_name, input logic [31:0] expected,
                           input logic [31:0] actual);
  if (actual !== expected) begin
    $display("Fail %s: expected %h, actual %h", test_name, expected, actual);
    fail_and_stop();
  end
endtask

// Store strobe for one cycle and then idle strobes
task automatic write_mem(input logic [ADDR_WIDTH-1:0] a, input logic [31:0] d,
                         input access_size_t s);
  @(posedge clk);
  rd    <= 1'b0;
  wr    <= 1'b1;
  addr  <= a;
  wdata <= d;
  size  <= s;
  drive_idle();
endtask

task automatic strobe_load(input logic [ADDR_WIDTH-1:0] a, input access_size_t s);
  @(posedge clk);
  rd   <= 1'b1;
  wr   <= 1'b0;
  addr <= a;
  size <= s;
endtask

task automatic strobe_fetch(input logic [ADDR_WIDTH-1:0] a);
  @(posedge clk);
  fetch      <= 1'b1;
  fetch_addr <= a;
endtask

task automatic drive_idle();
  @(posedge clk);
  rd    <= 1'b0;
  wr    <= 1'b0;
  fetch <= 1'b0;
endtask

// Cycles are counted from the edge that samples the strobe
task automatic wait_load(input string test_name, output logic [31:0] data,
                         output int cycles);
  cycles = 0;
  do begin
    @(posedge clk);
    cycles++;
    if (instr_valid) begin
      $display("Instruction response appeared during %s", test_name);
      fail_and_stop();
    end
    if (cycles > WAIT_LIMIT) begin
      $display("Timed out waiting for a load response in %s", test_name);
      fail_and_stop();
    end
  end while (!ld_valid);
  data = ld_data;
endtask

task automatic wait_fetch(input string test_name, output logic [31:0] data,
                          output int cycles);
  cycles = 0;
  do begin
    @(posedge clk);
    cycles++;
    if (ld_valid) begin
      $display("Load response appeared during %s", test_name);
      fail_and_stop();
    end
    if (cycles > WAIT_LIMIT) begin
      $display("Timed out waiting for an instruction response in %s", test_name);
      fail_and_stop();
    end
  end while (!instr_valid);
  data = instr;
endtask

task automatic load_and_check(input string test_name, input logic [ADDR_WIDTH-1:0] a,
                              input access_size_t s, input logic [31:0] expected,
                              output int cycles);
  logic [31:0] data;
  strobe_load(a, s);
  drive_idle();
  wait_load(test_name, data, cycles);
  check_value(test_name, expected, data);
endtask

task automatic word_round_trip();
  logic [ADDR_WIDTH-1:0] a;
  logic [31:0]           d;
  int                    cycles;
  a = ADDR_WIDTH'(($urandom % 64) * 4);  // Region 0x000 to 0x0fc
  d = $urandom;
  write_mem(a, d, WORD);
  load_and_check("word_round_trip", a, WORD, d, cycles);
  check_value("word_round_trip latency", 32'(LOAD_LATENCY), 32'(cycles));
endtask

task automatic byte_lanes();
  logic [ADDR_WIDTH-1:0] base;
  logic [31:0]           d [4];
  logic [31:0]           expected;
  int                    lane;
  int                    cycles;
  base = ADDR_WIDTH'(12'h100 + ($urandom % 64) * 4);
  for (int i = 0; i < 4; i++) begin
    d[i] = $urandom;  // Upper bits must not reach memory
    write_mem(ADDR_WIDTH'(base + i), d[i], BYTE);
  end
  expected = {d[3][7:0], d[2][7:0], d[1][7:0], d[0][7:0]};  // Little-endian
  load_and_check("byte_lanes word", base, WORD, expected, cycles);
  lane = $urandom % 4;
  load_and_check("byte_lanes byte", ADDR_WIDTH'(base + lane), BYTE,
                 {24'h0, d[lane][7:0]}, cycles);
endtask

task automatic unwritten_reads_zero();
  logic [ADDR_WIDTH-1:0] a;
  int                    cycles;
  a = ADDR_WIDTH'(12'h300 + ($urandom % 64) * 4);  // Region no test writes before
  load_and_check("unwritten_reads_zero", a, WORD, 32'h0, cycles);
endtask

task automatic fetch_after_store();
  logic [ADDR_WIDTH-1:0] a;
  logic [31:0]           d;
  logic [31:0]           data;
  int                    cycles;
  a = ADDR_WIDTH'(12'h200 + ($urandom % 64) * 4);
  d = $urandom;
  write_mem(a, d, WORD);
  strobe_fetch(a);
  drive_idle();
  wait_fetch("fetch_after_store", data, cycles);
  check_value("fetch_after_store", d, data);
  check_value("fetch_after_store latency", 32'(LOAD_LATENCY), 32'(cycles));
endtask

// Fetch and load in one cycle where the losing side shows busy for one cycle
task automatic contested_access(input string test_name, input bit instr_wins);
  logic [ADDR_WIDTH-1:0] ia;
  logic [ADDR_WIDTH-1:0] da;
  logic [31:0]           id;
  logic [31:0]           dd;
  bit                    got_i;
  bit                    got_d;
  int                    fetch_busy_cycles;
  int                    ls_busy_cycles;
  int                    cycles;
  ia = ADDR_WIDTH'(12'h200 + ($urandom % 32) * 4);
  da = ADDR_WIDTH'(12'h280 + ($urandom % 32) * 4);
  id = $urandom;
  dd = $urandom;
  write_mem(ia, id, WORD);
  write_mem(da, dd, WORD);
  @(posedge clk);
  fetch      <= 1'b1;
  fetch_addr <= ia;
  rd         <= 1'b1;
  wr         <= 1'b0;
  addr       <= da;
  size       <= WORD;
  drive_idle();
  got_i             = 1'b0;
  got_d             = 1'b0;
  fetch_busy_cycles = 0;
  ls_busy_cycles    = 0;
  cycles            = 0;
  while (!(got_i && got_d)) begin
    @(posedge clk);
    cycles++;
    if (fetch_busy) begin
      fetch_busy_cycles++;
    end
    if (ls_busy) begin
      ls_busy_cycles++;
    end
    if (instr_valid) begin
      got_i = 1'b1;
      check_value({test_name, " instr"}, id, instr);
    end
    if (ld_valid) begin
      got_d = 1'b1;
      check_value({test_name, " load"}, dd, ld_data);
    end
    if (cycles > WAIT_LIMIT) begin
      $display("Timed out waiting for both responses in %s", test_name);
      fail_and_stop();
    end
  end
  check_value({test_name, " fetch busy"}, instr_wins ? 32'd0 : 32'd1, 32'(fetch_busy_cycles));
  check_value({test_name, " ls busy"}, instr_wins ? 32'd1 : 32'd0, 32'(ls_busy_cycles));
endtask

task automatic back_to_back_loads();
  logic [ADDR_WIDTH-1:0] a [8];
  logic [31:0]           d [8];
  logic [31:0]           data;
  int                    cycles;
  for (int k = 0; k < 8; k++) begin
    a[k] = ADDR_WIDTH'(k * 32 + ($urandom % 8) * 4);  // One word per 32-byte slot
    d[k] = $urandom;
    write_mem(a[k], d[k], WORD);
  end
  for (int k = 0; k < 8; k++) begin
    strobe_load(a[k], WORD);
  end
  drive_idle();
  wait_load("back_to_back_loads", data, cycles);
  check_value("back_to_back_loads 0", d[0], data);
  for (int k = 1; k < 8; k++) begin
    @(posedge clk);
    if (!ld_valid) begin
      $display("Load response %0d missing its cycle in back_to_back_loads", k);
      fail_and_stop();
    end
    check_value($sformatf("back_to_back_loads %0d", k), d[k], ld_data);
  end
endtask

`endif

// File: test/tb_mem_subsystem.sv
module tb_mem_subsystem;
  import mem_params_pkg::*;
  import mem_types_pkg::*;

  localparam int LOAD_LATENCY = 10;  // Strobe to response when uncontested

  logic                  clk;
  logic                  rst;
  logic                  fetch;
  logic [ADDR_WIDTH-1:0] fetch_addr;
  logic                  fetch_busy;
  logic                  instr_valid;
  logic [31:0]           instr;
  logic                  rd;
  logic                  wr;
  logic [ADDR_WIDTH-1:0] addr;
  logic [31:0]           wdata;
  access_size_t          size;
  logic                  ls_busy;
  logic                  ld_valid;
  logic [31:0]           ld_data;

  mem_subsystem #(
    .MEM_SIZE   (MEM_SIZE),
    .ADDR_WIDTH (ADDR_WIDTH)
  ) mem_subsystem_i (
    .clk_i         (clk),
    .rst_i         (rst),
    .fetch_i       (fetch),
    .fetch_addr_i  (fetch_addr),
    .fetch_busy_o  (fetch_busy),
    .instr_valid_o (instr_valid),
    .instr_o       (instr),
    .rd_i          (rd),
    .wr_i          (wr),
    .addr_i        (addr),
    .wdata_i       (wdata),
    .size_i        (size),
    .ls_busy_o     (ls_busy),
    .ld_valid_o    (ld_valid),
    .ld_data_o     (ld_data)
  );

  always #20 clk = ~clk;

  `include "tb_tasks.svh"

  initial begin
    clk        = 1'b0;
    rst        = 1'b0;  // Reset is active low
    fetch      = 1'b0;
    fetch_addr = '0;
    rd         = 1'b0;
    wr         = 1'b0;
    addr       = '0;
    wdata      = '0;
    size       = WORD;
    void'($urandom(32'h6f2b_e59d));

    repeat (10) @(posedge clk);
    rst <= 1'b1;
    @(posedge clk);
    // Busy and valid outputs all idle out of reset
    check_value("reset_state", 32'h0, {28'h0, fetch_busy, ls_busy, instr_valid, ld_valid});

    word_round_trip();
    byte_lanes();
    unwritten_reads_zero();
    fetch_after_store();
    contested_access("contest_first", 1'b0);   // Data preferred after reset
    contested_access("contest_second", 1'b1);
    back_to_back_loads();

    repeat (2) @(posedge clk);
    $display("Simulation passed");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+test
common/mem_params_pkg.sv
common/mem_types_pkg.sv
memory/main_mem.sv
memory/mem_arbiter.sv
rtl/fetch_port.sv
rtl/load_store_port.sv
rtl/mem_subsystem.sv
test/tb_mem_subsystem.sv
